// ==== Makefile ====
TOP := tb_liteic_rd

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+logic
logic/liteic_pkg.sv
logic/liteic_rd_if.sv
logic/rd_rr_arbiter.sv
logic/rd_resp_timer.sv
logic/rd_slave_fsm.sv
logic/rd_master_port.sv
logic/liteic_rd_top.sv
sim/liteic_rd_asserts.sv
sim/tb_liteic_rd.sv

// ==== logic/liteic_defs.svh ====
`ifndef LITEIC_DEFS_SVH
`define LITEIC_DEFS_SVH

// crossbar size
`define LITEIC_NUM_MST 2
`define LITEIC_NUM_SLV 2

// axi-lite read channel widths
`define LITEIC_ADDR_W 32
`define LITEIC_DATA_W 32
`define LITEIC_RESP_W 2

// 1 MiB windows, picked by addr[23:20]
`define LITEIC_RGN_NIBBLE_0 4'h1
`define LITEIC_RGN_NIBBLE_1 4'h2

// rresp codes
`define LITEIC_RESP_OKAY   2'd0
`define LITEIC_RESP_SLVERR 2'd2
`define LITEIC_RESP_DECERR 2'd3

// cycles a node waits for slave read data
`define LITEIC_RESP_TIMEOUT 32

`endif

// ==== logic/liteic_pkg.sv ====
`include "liteic_defs.svh"

package liteic_pkg;

    // bus payloads
    typedef logic [`LITEIC_ADDR_W-1:0] addr_t;
    typedef logic [`LITEIC_DATA_W-1:0] data_t;
    typedef logic [`LITEIC_RESP_W-1:0] resp_t;

    // one-hot selects
    typedef logic [`LITEIC_NUM_MST-1:0] mst_sel_t;
    typedef logic [`LITEIC_NUM_SLV-1:0] slv_sel_t;

    // watchdog count, must hold the timeout value itself
    typedef logic [$clog2(`LITEIC_RESP_TIMEOUT+1)-1:0] tmr_cnt_t;

    // slave node states
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA,
        RD_RESP
    } rd_state_e;

endpackage

// ==== logic/liteic_rd_if.sv ====
`timescale 1ns/1ps
`include "liteic_defs.svh"

interface liteic_rd_if
    import liteic_pkg::*;
();

    // master port -> slave nodes
    slv_sel_t req;
    addr_t    addr;
    logic     r_ready;

    // slave node s -> master port, element s only
    logic     grant   [`LITEIC_NUM_SLV];
    logic     r_valid [`LITEIC_NUM_SLV];
    data_t    r_data  [`LITEIC_NUM_SLV];
    resp_t    r_resp  [`LITEIC_NUM_SLV];

    // master port view
    modport mst_side (
        output req, addr, r_ready,
        input  grant, r_valid, r_data, r_resp
    );

    // slave node view
    modport slv_side (
        input req, addr, r_ready
    );

endinterface

// ==== logic/liteic_rd_top.sv ====
`timescale 1ns/1ps
`include "liteic_defs.svh"

module liteic_rd_top
    import liteic_pkg::*;
(
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    // master side
    input  addr_t [`LITEIC_NUM_MST-1:0]        m_ar_addr_i,
    input  mst_sel_t                           m_ar_valid_i,
    output mst_sel_t                           m_ar_ready_o,
    output data_t [`LITEIC_NUM_MST-1:0]        m_r_data_o,
    output resp_t [`LITEIC_NUM_MST-1:0]        m_r_resp_o,
    output mst_sel_t                           m_r_valid_o,
    input  mst_sel_t                           m_r_ready_i,
    // slave side
    output addr_t [`LITEIC_NUM_SLV-1:0]        s_ar_addr_o,
    output slv_sel_t                           s_ar_valid_o,
    input  slv_sel_t                           s_ar_ready_i,
    input  data_t [`LITEIC_NUM_SLV-1:0]        s_r_data_i,
    input  resp_t [`LITEIC_NUM_SLV-1:0]        s_r_resp_i,
    input  slv_sel_t                           s_r_valid_i,
    output slv_sel_t                           s_r_ready_o
);

    // one link per master, shared by all nodes
    liteic_rd_if rd_link [`LITEIC_NUM_MST] ();

    // ------------------------------
    // master ports
    // ------------------------------
    for (genvar m = 0; m < `LITEIC_NUM_MST; m++) begin : g_mst_port
        rd_master_port u_mst (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .ar_addr_i  (m_ar_addr_i[m]),
            .ar_valid_i (m_ar_valid_i[m]),
            .ar_ready_o (m_ar_ready_o[m]),
            .r_data_o   (m_r_data_o[m]),
            .r_resp_o   (m_r_resp_o[m]),
            .r_valid_o  (m_r_valid_o[m]),
            .r_ready_i  (m_r_ready_i[m]),
            .link       (rd_link[m])
        );
    end

    // ------------------------------
    // slave nodes
    // ------------------------------
    for (genvar s = 0; s < `LITEIC_NUM_SLV; s++) begin : g_slv_node
        // region of this node
        localparam logic [3:0] RGN = (s == 0) ? `LITEIC_RGN_NIBBLE_0 : `LITEIC_RGN_NIBBLE_1;

        mst_sel_t nd_grant;
        mst_sel_t nd_valid;
        data_t    nd_data;
        resp_t    nd_resp;

        rd_slave_fsm u_slv (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .rgn_link    (rd_link),
            .rgn_i       (RGN),
            .lnk_grant_o (nd_grant),
            .lnk_valid_o (nd_valid),
            .lnk_data_o  (nd_data),
            .lnk_resp_o  (nd_resp),
            .ar_addr_o   (s_ar_addr_o[s]),
            .ar_valid_o  (s_ar_valid_o[s]),
            .ar_ready_i  (s_ar_ready_i[s]),
            .r_data_i    (s_r_data_i[s]),
            .r_resp_i    (s_r_resp_i[s]),
            .r_valid_i   (s_r_valid_i[s]),
            .r_ready_o   (s_r_ready_o[s])
        );

        // node s owns element s of every link
        for (genvar m = 0; m < `LITEIC_NUM_MST; m++) begin : g_link
            assign rd_link[m].grant[s]   = nd_grant[m];
            assign rd_link[m].r_valid[s] = nd_valid[m];
            assign rd_link[m].r_data[s]  = nd_data;
            assign rd_link[m].r_resp[s]  = nd_resp;
        end
    end

endmodule

// ==== logic/rd_master_port.sv ====
`timescale 1ns/1ps
`include "liteic_defs.svh"

module rd_master_port
    import liteic_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  addr_t         ar_addr_i,
    input  logic          ar_valid_i,
    output logic          ar_ready_o,
    output data_t         r_data_o,
    output resp_t         r_resp_o,
    output logic          r_valid_o,
    input  logic          r_ready_i,
    liteic_rd_if.mst_side link
);

    slv_sel_t hit;
    slv_sel_t gnt_vec;
    slv_sel_t rv_vec;
    slv_sel_t sel_q;
    logic     top_zero;
    logic     legal;
    logic     idle;
    logic     busy_q;
    logic     dec_ar_q;
    logic     dec_rsp_q;
    data_t    sel_data;
    resp_t    sel_resp;

    // ------------------------------
    // address decode
    // ------------------------------
    assign top_zero = ~|ar_addr_i[31:24];
    assign hit[0]   = top_zero && (ar_addr_i[23:20] == `LITEIC_RGN_NIBBLE_0);
    assign hit[1]   = top_zero && (ar_addr_i[23:20] == `LITEIC_RGN_NIBBLE_1);
    assign legal    = |hit;

    // nothing outstanding, no decerr in progress
    assign idle = !busy_q && !dec_ar_q && !dec_rsp_q;

    // request only toward the matching node
    assign link.req     = (ar_valid_i && idle) ? hit : '0;
    assign link.addr    = ar_addr_i;
    assign link.r_ready = r_ready_i && busy_q;

    // gather node outputs, keep the granted slave's response
    always_comb begin
        gnt_vec  = '0;
        rv_vec   = '0;
        sel_data = '0;
        sel_resp = `LITEIC_RESP_OKAY;
        for (int s = 0; s < `LITEIC_NUM_SLV; s++) begin
            gnt_vec[s] = link.grant[s];
            rv_vec[s]  = link.r_valid[s] && sel_q[s];
            if (sel_q[s]) begin
                sel_data = link.r_data[s];
                sel_resp = link.r_resp[s];
            end
        end
    end

    // ar transfer is either a node grant or the local decerr pulse
    assign ar_ready_o = (|gnt_vec) || dec_ar_q;

    assign r_valid_o = busy_q ? |rv_vec : dec_rsp_q;
    assign r_data_o  = dec_rsp_q ? '0 : sel_data;
    assign r_resp_o  = dec_rsp_q ? `LITEIC_RESP_DECERR : sel_resp;

    // ------------------------------
    // outstanding read tracking
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            sel_q     <= '0;
            dec_ar_q  <= 1'b0;
            dec_rsp_q <= 1'b0;
        end else begin
            // illegal address, accept one cycle later
            dec_ar_q <= ar_valid_i && idle && !legal;
            // decerr response right after that transfer
            if (dec_ar_q) begin
                dec_rsp_q <= 1'b1;
            end else if (dec_rsp_q && r_ready_i) begin
                dec_rsp_q <= 1'b0;
            end
            // grant opens the read, response handshake closes it
            if (|gnt_vec) begin
                busy_q <= 1'b1;
                sel_q  <= gnt_vec;
            end else if (busy_q && r_valid_o && r_ready_i) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/rd_resp_timer.sv ====
`timescale 1ns/1ps
`include "liteic_defs.svh"

module rd_resp_timer
    import liteic_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic run_i,
    output logic expired_o
);

    tmr_cnt_t cnt_q;

    // counts while waiting, parks at the limit
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (!run_i) begin
            cnt_q <= '0;
        end else if (!expired_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign expired_o = (cnt_q == tmr_cnt_t'(`LITEIC_RESP_TIMEOUT));

endmodule

// ==== logic/rd_rr_arbiter.sv ====
`timescale 1ns/1ps
`include "liteic_defs.svh"

module rd_rr_arbiter
    import liteic_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  mst_sel_t req_i,
    input  logic     advance_i,
    output mst_sel_t grant_o
);

    localparam int PTR_W = (`LITEIC_NUM_MST > 1) ? $clog2(`LITEIC_NUM_MST) : 1;

    // index of the last winner
    logic [PTR_W-1:0] last_q;
    logic [PTR_W-1:0] win_idx;

    // search starts just after the last winner
    always_comb begin
        int unsigned idx;
        logic        found;
        grant_o = '0;
        win_idx = last_q;
        found   = 1'b0;
        for (int i = 0; i < `LITEIC_NUM_MST; i++) begin
            idx = (int'(last_q) + 1 + i) % `LITEIC_NUM_MST;
            if (!found && req_i[idx]) begin
                grant_o[idx] = 1'b1;
                win_idx      = PTR_W'(idx);
                found        = 1'b1;
            end
        end
    end

    // pointer moves past the winner only on an accepted grant
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // so master 0 goes first after reset
            last_q <= PTR_W'(`LITEIC_NUM_MST - 1);
        end else if (advance_i && (|grant_o)) begin
            last_q <= win_idx;
        end
    end

endmodule

// ==== logic/rd_slave_fsm.sv ====
`timescale 1ns/1ps
`include "liteic_defs.svh"

module rd_slave_fsm
    import liteic_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    liteic_rd_if.slv_side rgn_link [`LITEIC_NUM_MST],
    input  logic [3:0]    rgn_i,
    output mst_sel_t      lnk_grant_o,
    output mst_sel_t      lnk_valid_o,
    output data_t         lnk_data_o,
    output resp_t         lnk_resp_o,
    output addr_t         ar_addr_o,
    output logic          ar_valid_o,
    input  logic          ar_ready_i,
    input  data_t         r_data_i,
    input  resp_t         r_resp_i,
    input  logic          r_valid_i,
    output logic          r_ready_o
);

    rd_state_e state_q;
    mst_sel_t  req_vec;
    mst_sel_t  rdy_vec;
    mst_sel_t  arb_req;
    mst_sel_t  arb_gnt;
    mst_sel_t  win_q;
    addr_t     req_addr [`LITEIC_NUM_MST];
    addr_t     gnt_addr;
    addr_t     ar_addr_q;
    data_t     rsp_data_q;
    resp_t     rsp_resp_q;
    logic      idle;
    logic      tmr_run;
    logic      tmr_expired;

    // per-master view of the links
    for (genvar m = 0; m < `LITEIC_NUM_MST; m++) begin : g_mst
        // req is one-hot, region nibble says whether it is ours
        assign req_vec[m]  = (|rgn_link[m].req) && (rgn_link[m].addr[23:20] == rgn_i);
        assign req_addr[m] = rgn_link[m].addr;
        assign rdy_vec[m]  = rgn_link[m].r_ready;
    end

    assign idle    = (state_q == RD_IDLE);
    assign arb_req = idle ? req_vec : '0;
    assign tmr_run = (state_q == RD_DATA);

    rd_rr_arbiter u_arb (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (arb_req),
        .advance_i (idle),
        .grant_o   (arb_gnt)
    );

    rd_resp_timer u_tmr (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .run_i     (tmr_run),
        .expired_o (tmr_expired)
    );

    // address of the winning master
    always_comb begin
        gnt_addr = '0;
        for (int m = 0; m < `LITEIC_NUM_MST; m++) begin
            if (arb_gnt[m]) begin
                gnt_addr = req_addr[m];
            end
        end
    end

    // ------------------------------
    // outputs
    // ------------------------------
    assign lnk_grant_o = arb_gnt;
    assign lnk_valid_o = (state_q == RD_RESP) ? win_q : '0;
    assign lnk_data_o  = rsp_data_q;
    assign lnk_resp_o  = rsp_resp_q;
    assign ar_addr_o   = ar_addr_q;
    assign ar_valid_o  = (state_q == RD_ADDR);
    assign r_ready_o   = (state_q == RD_DATA);

    // ------------------------------
    // state machine
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= RD_IDLE;
            win_q   <= '0;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (|arb_gnt) begin
                        win_q   <= arb_gnt;
                        state_q <= RD_ADDR;
                    end
                end
                RD_ADDR: if (ar_ready_i) state_q <= RD_DATA;
                RD_DATA: if (r_valid_i || tmr_expired) state_q <= RD_RESP;
                // hold until the winner takes it
                RD_RESP: if (|(win_q & rdy_vec)) state_q <= RD_IDLE;
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    // address and response capture
    always_ff @(posedge clk_i) begin
        if (idle && (|arb_gnt)) begin
            ar_addr_q <= gnt_addr;
        end
        if (state_q == RD_DATA) begin
            // real data wins over a same-cycle expiry
            if (r_valid_i) begin
                rsp_data_q <= r_data_i;
                rsp_resp_q <= r_resp_i;
            end else if (tmr_expired) begin
                rsp_data_q <= '0;
                rsp_resp_q <= `LITEIC_RESP_SLVERR;
            end
        end
    end

endmodule

// ==== sim/liteic_rd_asserts.sv ====
`timescale 1ns/1ps
`include "liteic_defs.svh"

module liteic_rd_asserts
    import liteic_pkg::*;
(
    input logic                        clk_i,
    input logic                        rst_n_i,
    input mst_sel_t                    m_r_valid_o,
    input mst_sel_t                    m_r_ready_i,
    input data_t [`LITEIC_NUM_MST-1:0] m_r_data_o,
    input resp_t [`LITEIC_NUM_MST-1:0] m_r_resp_o,
    input addr_t [`LITEIC_NUM_SLV-1:0] s_ar_addr_o,
    input slv_sel_t                    s_ar_valid_o,
    input slv_sel_t                    s_ar_ready_i,
    input slv_sel_t                    s_r_ready_o
);

    // slave address channel holds until accepted
    for (genvar s = 0; s < `LITEIC_NUM_SLV; s++) begin : g_slv
        ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            s_ar_valid_o[s] && !s_ar_ready_i[s]
                |=> s_ar_valid_o[s] && $stable(s_ar_addr_o[s]))
            else $error("slave %0d address channel changed before s_ar_ready_i", s);
    end

    // master response holds under back-pressure
    for (genvar m = 0; m < `LITEIC_NUM_MST; m++) begin : g_mst
        r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            m_r_valid_o[m] && !m_r_ready_i[m]
                |=> m_r_valid_o[m] && $stable(m_r_data_o[m]) && $stable(m_r_resp_o[m]))
            else $error("master %0d response changed before m_r_ready_i", m);
    end

    // sync reset, outputs quiet one cycle after a reset edge
    rst_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !(|m_r_valid_o) && !(|s_ar_valid_o) && !(|s_r_ready_o))
        else $error("valid output high during reset");

endmodule

bind liteic_rd_top liteic_rd_asserts u_asserts (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .m_r_valid_o  (m_r_valid_o),
    .m_r_ready_i  (m_r_ready_i),
    .m_r_data_o   (m_r_data_o),
    .m_r_resp_o   (m_r_resp_o),
    .s_ar_addr_o  (s_ar_addr_o),
    .s_ar_valid_o (s_ar_valid_o),
    .s_ar_ready_i (s_ar_ready_i),
    .s_r_ready_o  (s_r_ready_o)
);

// ==== sim/tb_liteic_rd.sv ====
`timescale 1ns/1ps
`include "liteic_defs.svh"

module tb_liteic_rd
    import liteic_pkg::*;
();

    localparam int    WAIT_LIMIT = 200;
    localparam int    NUM_RAND   = 200;
    localparam data_t DATA_TAG   = 32'ha5c3_0f96;

    logic clk_i;
    logic rst_n_i;

    // master side
    addr_t [`LITEIC_NUM_MST-1:0] m_ar_addr;
    mst_sel_t                    m_ar_valid;
    mst_sel_t                    m_ar_ready;
    data_t [`LITEIC_NUM_MST-1:0] m_r_data;
    resp_t [`LITEIC_NUM_MST-1:0] m_r_resp;
    mst_sel_t                    m_r_valid;
    mst_sel_t                    m_r_ready;
    // slave side
    addr_t [`LITEIC_NUM_SLV-1:0] s_ar_addr;
    slv_sel_t                    s_ar_valid;
    slv_sel_t                    s_ar_ready;
    data_t [`LITEIC_NUM_SLV-1:0] s_r_data;
    resp_t [`LITEIC_NUM_SLV-1:0] s_r_resp;
    slv_sel_t                    s_r_valid;
    slv_sel_t                    s_r_ready;

    logic [31:0] lfsr_q = 32'h5d31df6f;
    int          ar_valid_cycles;
    // slave model phase (0 address, 1 data pending, 2 data shown)
    int          slv_state [`LITEIC_NUM_SLV];
    int          slv_ar_wait [`LITEIC_NUM_SLV];
    int          slv_r_wait  [`LITEIC_NUM_SLV];
    addr_t       slv_addr_q  [`LITEIC_NUM_SLV];

    liteic_rd_top i_dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .m_ar_addr_i  (m_ar_addr),
        .m_ar_valid_i (m_ar_valid),
        .m_ar_ready_o (m_ar_ready),
        .m_r_data_o   (m_r_data),
        .m_r_resp_o   (m_r_resp),
        .m_r_valid_o  (m_r_valid),
        .m_r_ready_i  (m_r_ready),
        .s_ar_addr_o  (s_ar_addr),
        .s_ar_valid_o (s_ar_valid),
        .s_ar_ready_i (s_ar_ready),
        .s_r_data_i   (s_r_data),
        .s_r_resp_i   (s_r_resp),
        .s_r_valid_i  (s_r_valid),
        .s_r_ready_o  (s_r_ready)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    // fibonacci lfsr x^32 + x^22 + x^2 + x + 1
    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // slave models never answer these addresses
    // about 1 in 8 of random legal addresses
    function automatic logic is_silent(input addr_t a);
        return a[4:2] == 3'b111;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // random address in region s
    // quiet keeps it away from a silent slave
    function automatic addr_t make_legal(input int s, input logic quiet);
        addr_t a;
        a = {8'h00, (s == 0) ? `LITEIC_RGN_NIBBLE_0 : `LITEIC_RGN_NIBBLE_1, 20'(rand_bits(20))};
        if (quiet) begin
            a[4] = 1'b0;
        end
        return a;
    endfunction

    // nonzero top byte or a nibble outside both regions
    function automatic addr_t make_illegal();
        logic [7:0] top;
        logic [3:0] nib;
        if (rand_bits(1) == 32'd1) begin
            top = 8'(rand_bits(8));
            if (top == 8'h00) begin
                top = 8'h40;
            end
            return {top, 24'(rand_bits(24))};
        end
        nib = 4'(rand_bits(4));
        if (nib == `LITEIC_RGN_NIBBLE_0 || nib == `LITEIC_RGN_NIBBLE_1) begin
            nib = nib ^ 4'h8;
        end
        return {8'h00, nib, 20'(rand_bits(20))};
    endfunction

    // reference model predicts from the address alone
    task automatic predict_read(input addr_t a, output data_t d, output resp_t r);
        logic legal;
        legal = (a[31:24] == 8'h00) &&
                (a[23:20] == `LITEIC_RGN_NIBBLE_0 || a[23:20] == `LITEIC_RGN_NIBBLE_1);
        d = '0;
        if (!legal) begin
            r = `LITEIC_RESP_DECERR;
        end else if (is_silent(a)) begin
            r = `LITEIC_RESP_SLVERR;
        end else begin
            d = a ^ DATA_TAG;
            r = `LITEIC_RESP_OKAY;
        end
    endtask

    // ------------------------------
    // master driver
    // ------------------------------
    task automatic do_read(input int m, input addr_t a, output data_t d, output resp_t r);
        int   cnt;
        logic done;
        m_ar_addr[m]  <= a;
        m_ar_valid[m] <= 1'b1;
        cnt  = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk_i);
            if (m_ar_ready[m]) begin
                done = 1'b1;
            end else if (cnt == WAIT_LIMIT) begin
                abort_run($sformatf("master %0d saw no ar_ready for address %h", m, a));
            end else begin
                cnt++;
            end
        end
        m_ar_valid[m] <= 1'b0;
        m_r_ready[m]  <= (rand_bits(2) != 32'd0);
        cnt  = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk_i);
            if (m_r_valid[m] && m_r_ready[m]) begin
                d = m_r_data[m];
                r = m_r_resp[m];
                m_r_ready[m] <= 1'b0;
                done = 1'b1;
            end else if (cnt == WAIT_LIMIT) begin
                abort_run($sformatf("master %0d got no response for address %h", m, a));
            end else begin
                // random back-pressure with ready about 3 cycles in 4
                m_r_ready[m] <= (rand_bits(2) != 32'd0);
                cnt++;
            end
        end
    endtask

    task automatic run_read(input int m, input addr_t a, input string name);
        data_t got_d;
        data_t exp_d;
        resp_t got_r;
        resp_t exp_r;
        do_read(m, a, got_d, got_r);
        predict_read(a, exp_d, exp_r);
        check_value($sformatf("%s data @%h", name, a), exp_d, got_d);
        check_value($sformatf("%s resp @%h", name, a), 32'(exp_r), 32'(got_r));
    endtask

    task automatic mixed_reads(input int m);
        addr_t a;
        for (int i = 0; i < NUM_RAND; i++) begin
            if (rand_bits(3) == 32'd0) begin
                a = make_illegal();
            end else begin
                a = make_legal(int'(rand_bits(1)), 1'b0);
            end
            run_read(m, a, $sformatf("t5 m%0d read %0d", m, i));
        end
    endtask

    // ------------------------------
    // slave models
    // ------------------------------
    task automatic go_idle(input int s);
        slv_ar_wait[s] = int'(rand_bits(2));
        s_ar_ready[s] <= (slv_ar_wait[s] == 0);
        slv_state[s]   = 0;
    endtask

    task automatic step_slave(input int s);
        case (slv_state[s])
            0: begin
                if (s_ar_valid[s] && s_ar_ready[s]) begin
                    slv_addr_q[s]  = s_ar_addr[s];
                    slv_r_wait[s]  = int'(rand_bits(3)) + 1;
                    s_ar_ready[s] <= 1'b0;
                    slv_state[s]   = 1;
                end else if (s_ar_valid[s]) begin
                    if (slv_ar_wait[s] <= 1) begin
                        s_ar_ready[s] <= 1'b1;
                    end else begin
                        slv_ar_wait[s]--;
                    end
                end
            end
            1: begin
                if (is_silent(slv_addr_q[s])) begin
                    // node gave up once it drops r_ready
                    if (!s_r_ready[s]) begin
                        go_idle(s);
                    end
                end else if (slv_r_wait[s] <= 1) begin
                    s_r_valid[s] <= 1'b1;
                    s_r_data[s]  <= slv_addr_q[s] ^ DATA_TAG;
                    s_r_resp[s]  <= `LITEIC_RESP_OKAY;
                    slv_state[s]  = 2;
                end else begin
                    slv_r_wait[s]--;
                end
            end
            default: begin
                if (s_r_valid[s] && s_r_ready[s]) begin
                    s_r_valid[s] <= 1'b0;
                    s_r_data[s]  <= '0;
                    go_idle(s);
                end
            end
        endcase
    endtask

    initial begin
        s_ar_ready <= '0;
        s_r_data   <= '0;
        s_r_resp   <= '0;
        s_r_valid  <= '0;
        for (int s = 0; s < `LITEIC_NUM_SLV; s++) begin
            slv_state[s]   = 0;
            slv_ar_wait[s] = 1;
        end
        forever begin
            @(posedge clk_i);
            if (rst_n_i) begin
                if (|s_ar_valid) begin
                    ar_valid_cycles++;
                end
                for (int s = 0; s < `LITEIC_NUM_SLV; s++) begin
                    step_slave(s);
                end
            end
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        addr_t a;
        int    base;
        ar_valid_cycles = 0;
        rst_n_i    <= 1'b0;
        m_ar_addr  <= '0;
        m_ar_valid <= '0;
        m_r_ready  <= '0;
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);

        // test 1 outputs quiet after reset
        check_value("t1 outputs after reset", 32'd0,
                    32'({m_ar_ready, m_r_valid, s_ar_valid, s_r_ready}));

        // test 2 single reads where the slave sees the master's address
        for (int m = 0; m < `LITEIC_NUM_MST; m++) begin
            for (int k = 0; k < 4; k++) begin
                a = make_legal(k % 2, 1'b1);
                run_read(m, a, $sformatf("t2 m%0d", m));
                check_value($sformatf("t2 m%0d slave addr", m), a, slv_addr_q[k % 2]);
            end
        end

        // test 3 decode errors never reach a slave
        base = ar_valid_cycles;
        for (int k = 0; k < 8; k++) begin
            run_read(k % 2, make_illegal(), "t3 decerr");
        end
        check_value("t3 s_ar_valid cycles", 32'(base), 32'(ar_valid_cycles));

        // test 4 silent slave then a normal read to it
        a      = make_legal(1, 1'b0);
        a[4:2] = 3'b111;
        run_read(0, a, "t4 silent");
        run_read(0, make_legal(1, 1'b1), "t4 after silent");

        // test 5 both masters at once
        fork
            mixed_reads(0);
            mixed_reads(1);
        join

        $display("All tests passed!");
        $finish;
    end

endmodule
